/* ddr_pic_pkg.sv */
package ddr_pic_pkg;

   //////////////////////////////////////////////////////////////////////
   // controller user port geometry
   //////////////////////////////////////////////////////////////////////

   parameter int unsigned PORT_DATA_W = 128;  // one user port word
   parameter int unsigned PORT_MASK_W = 16;   // one mask bit per byte
   parameter int unsigned BYTE_ADDR_W = 30;
   parameter int unsigned BL_W        = 6;    // burst length minus one
   parameter int unsigned INSTR_W     = 3;

   // bytes in one word, also the address step of one word
   parameter int unsigned WORD_BYTES  = 16;

   // first pixel word of the frame, restored on address reset
   parameter int unsigned FRAME_BASE_ADDR = 16;

   //////////////////////////////////////////////////////////////////////
   // command codes
   //////////////////////////////////////////////////////////////////////

   parameter logic [INSTR_W-1:0] CMD_WRITE = 3'b010;
   parameter logic [INSTR_W-1:0] CMD_READ  = 3'b001;

   //////////////////////////////////////////////////////////////////////
   // shared types
   //////////////////////////////////////////////////////////////////////

   typedef logic [PORT_DATA_W-1:0] port_word_t;
   typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;

endpackage

/* sd_word_packer.sv */
module sd_word_packer import ddr_pic_pkg::*; (
   input  logic       c3_clk0,
   input  logic       rst,
   input  logic       calib_done,
   input  logic [7:0] sd_byte,
   input  logic       sd_byte_valid,
   output logic       word_valid,
   output port_word_t word_data
);

   localparam int ACC_W = PORT_DATA_W - 8;        // first 15 bytes of a word
   localparam int CNT_W = $clog2(WORD_BYTES);

   logic [ACC_W-1:0] acc;
   logic [CNT_W-1:0] byte_cnt;
   logic             last_byte;

   // 16th byte of the current word
   assign last_byte = sd_byte_valid && (byte_cnt == CNT_W'(WORD_BYTES - 1));

   //////////////////////////////////////////////////////////////////////
   // byte counter and word strobe
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge c3_clk0) begin
      if (rst || !calib_done) begin
         byte_cnt   <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= last_byte;              // one cycle per full word
         if (last_byte) begin
            byte_cnt <= '0;
         end else if (sd_byte_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data path
   //////////////////////////////////////////////////////////////////////

   // oldest byte ends up in the top byte of the word
   always_ff @(posedge c3_clk0) begin
      if (sd_byte_valid) begin
         acc <= {acc[ACC_W-9:0], sd_byte};
      end
      if (last_byte) begin
         word_data <= {acc, sd_byte};          // held until the next word
      end
   end

endmodule

/* req_edge_sync.sv */
module req_edge_sync #(
   parameter int N_REQ = 3
) (
   input  logic             c3_clk0,
   input  logic             rst,
   input  logic             calib_done,
   input  logic [N_REQ-1:0] req_level,
   output logic [N_REQ-1:0] req_pulse
);

   logic [N_REQ-1:0] sync_1;
   logic [N_REQ-1:0] sync_2;
   logic [N_REQ-1:0] sync_3;                   // delayed copy for edge detect

   // two flops against metastability, then a registered rise detector
   always_ff @(posedge c3_clk0) begin
      if (rst || !calib_done) begin
         sync_1    <= '0;
         sync_2    <= '0;
         sync_3    <= '0;
         req_pulse <= '0;
      end else begin
         sync_1    <= req_level;
         sync_2    <= sync_1;
         sync_3    <= sync_2;
         req_pulse <= sync_2 & ~sync_3;        // one pulse per rise
      end
   end

endmodule

/* port_sequencer.sv */
module port_sequencer import ddr_pic_pkg::*; #(
   parameter int READ_BURST_LEN = 64
) (
   input  logic                   c3_clk0,
   input  logic                   rst,
   input  logic                   calib_done,
   input  logic                   pic_read_done,
   input  logic                   word_valid,
   input  port_word_t             word_data,
   input  logic                   addr_set,
   input  logic                   rd_cmd_req,
   input  logic                   rden_req,
   input  logic                   cmd_full,
   input  logic                   wr_full,
   output logic                   cmd_en,
   output logic [INSTR_W-1:0]     cmd_instr,
   output logic [BL_W-1:0]        cmd_bl,
   output byte_addr_t             cmd_byte_addr,
   output logic                   wr_en,
   output logic [PORT_MASK_W-1:0] wr_mask,
   output port_word_t             wr_data,
   output logic                   rd_en,
   output logic                   wr_busy,
   output logic                   word_drop
);

   // address step of one read burst, e.g. 64 words = 1024 bytes
   localparam byte_addr_t       RD_STEP  = byte_addr_t'(READ_BURST_LEN * WORD_BYTES);
   localparam logic [BL_W-1:0]  RD_BL    = BL_W'(READ_BURST_LEN - 1);
   localparam byte_addr_t       WR_STEP  = byte_addr_t'(WORD_BYTES);
   localparam byte_addr_t       BASE_ADR = byte_addr_t'(FRAME_BASE_ADDR);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WR_DATA,
      ST_WR_CMD_START,
      ST_WR_CMD,
      ST_RD_CMD_START,
      ST_RD_CMD
   } state_t;

   state_t     state;
   logic       pend_valid;                     // one-word slot is full
   port_word_t pend_data;
   logic       wr_done;
   logic       word_take;

   //////////////////////////////////////////////////////////////////////
   // pending word slot
   //////////////////////////////////////////////////////////////////////

   // slot frees on the write command pulse
   assign wr_done   = (state == ST_WR_CMD) && !cmd_full;
   assign word_take = word_valid && (!pend_valid || wr_done);

   always_ff @(posedge c3_clk0) begin
      if (rst || !calib_done) begin
         pend_valid <= 1'b0;
         word_drop  <= 1'b0;
      end else begin
         if (word_take) begin
            pend_valid <= 1'b1;
         end else if (wr_done) begin
            pend_valid <= 1'b0;
         end
         if (word_valid && !word_take) begin
            word_drop <= 1'b1;                 // sticky until reset
         end
      end
   end

   always_ff @(posedge c3_clk0) begin
      if (word_take) begin
         pend_data <= word_data;
      end
   end

   assign wr_data = pend_data;                 // stable while the slot is full
   assign wr_mask = '0;                        // all 16 bytes written
   assign wr_busy = pend_valid;

   // display strobe owns the read port
   assign rd_en = rden_req;

   //////////////////////////////////////////////////////////////////////
   // command / write port FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge c3_clk0) begin
      if (rst || !calib_done) begin
         state         <= ST_IDLE;
         cmd_en        <= 1'b0;
         cmd_instr     <= '0;
         cmd_bl        <= '0;
         cmd_byte_addr <= '0;
         wr_en         <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               cmd_en <= 1'b0;
               wr_en  <= 1'b0;
               // read burst just issued, move past it
               if (cmd_en && cmd_instr == CMD_READ) begin
                  cmd_byte_addr <= cmd_byte_addr + RD_STEP;
               end
               if (pend_valid) begin
                  state <= ST_WR_DATA;         // writes go first
               end else if (pic_read_done) begin
                  if (addr_set) begin
                     cmd_byte_addr <= BASE_ADR;
                  end else if (rd_cmd_req) begin
                     state <= ST_RD_CMD_START;
                  end
               end
            end

            ST_WR_DATA: begin
               if (!wr_full) begin
                  wr_en <= 1'b1;
                  state <= ST_WR_CMD_START;
               end
            end

            ST_WR_CMD_START: begin
               wr_en         <= 1'b0;
               cmd_instr     <= CMD_WRITE;
               cmd_bl        <= '0;            // single word burst
               cmd_byte_addr <= cmd_byte_addr + WR_STEP;
               state         <= ST_WR_CMD;
            end

            ST_WR_CMD: begin
               if (!cmd_full) begin
                  cmd_en <= 1'b1;
                  state  <= ST_IDLE;
               end
            end

            ST_RD_CMD_START: begin
               cmd_instr <= CMD_READ;
               cmd_bl    <= RD_BL;
               state     <= ST_RD_CMD;
            end

            ST_RD_CMD: begin
               // waits for room in the command FIFO
               if (!cmd_full) begin
                  cmd_en <= 1'b1;
                  state  <= ST_IDLE;
               end
            end

            default: begin
               cmd_en <= 1'b0;
               wr_en  <= 1'b0;
               state  <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

/* ddr_pic_top.sv */
module ddr_pic_top import ddr_pic_pkg::*; #(
   parameter int READ_BURST_LEN = 64
) (
   input  logic                   c3_clk0,
   input  logic                   rst,
   input  logic                   calib_done,

   // SD picture loader
   input  logic [7:0]             sd_byte,
   input  logic                   sd_byte_valid,
   input  logic                   pic_read_done,

   // display side, level signals
   input  logic                   disp_addr_set,
   input  logic                   disp_rd_cmd,
   input  logic                   disp_rden,

   // controller user port 0
   input  logic                   cmd_full,
   input  logic                   wr_full,
   input  port_word_t             rd_data,
   output logic                   cmd_en,
   output logic [INSTR_W-1:0]     cmd_instr,
   output logic [BL_W-1:0]        cmd_bl,
   output byte_addr_t             cmd_byte_addr,
   output logic                   wr_en,
   output logic [PORT_MASK_W-1:0] wr_mask,
   output port_word_t             wr_data,
   output logic                   rd_en,

   output port_word_t             ddr_data,
   output logic                   wr_busy,
   output logic                   word_drop
);

   logic       word_valid;
   port_word_t word_data;
   logic [2:0] disp_req_pulse;
   logic       addr_set;
   logic       rd_cmd_req;
   logic       rden_req;

   assign {addr_set, rd_cmd_req, rden_req} = disp_req_pulse;

   assign ddr_data = rd_data;                  // read FIFO output, no register

   //////////////////////////////////////////////////////////////////////
   // byte packing and request conditioning
   //////////////////////////////////////////////////////////////////////

   sd_word_packer sd_word_packer_inst (
      .c3_clk0       (c3_clk0),
      .rst           (rst),
      .calib_done    (calib_done),
      .sd_byte       (sd_byte),
      .sd_byte_valid (sd_byte_valid),
      .word_valid    (word_valid),
      .word_data     (word_data)
   );

   req_edge_sync #(
      .N_REQ (3)
   ) req_edge_sync_inst (
      .c3_clk0    (c3_clk0),
      .rst        (rst),
      .calib_done (calib_done),
      .req_level  ({disp_addr_set, disp_rd_cmd, disp_rden}),
      .req_pulse  (disp_req_pulse)
   );

   //////////////////////////////////////////////////////////////////////
   // controller port sequencing
   //////////////////////////////////////////////////////////////////////

   port_sequencer #(
      .READ_BURST_LEN (READ_BURST_LEN)
   ) port_sequencer_inst (
      .c3_clk0       (c3_clk0),
      .rst           (rst),
      .calib_done    (calib_done),
      .pic_read_done (pic_read_done),
      .word_valid    (word_valid),
      .word_data     (word_data),
      .addr_set      (addr_set),
      .rd_cmd_req    (rd_cmd_req),
      .rden_req      (rden_req),
      .cmd_full      (cmd_full),
      .wr_full       (wr_full),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_mask       (wr_mask),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .wr_busy       (wr_busy),
      .word_drop     (word_drop)
   );

endmodule

/* ddr_pic_checker.sv */
module ddr_pic_checker import ddr_pic_pkg::*; #(
   parameter int READ_BURST_LEN = 64
) (
   input logic                   c3_clk0,
   input logic                   rst,
   input logic                   calib_done,
   input logic [7:0]             sd_byte,
   input logic                   sd_byte_valid,
   input logic                   pic_read_done,
   input logic                   disp_addr_set,
   input logic                   disp_rden,
   input logic                   cmd_full,
   input logic                   wr_full,
   input logic                   cmd_en,
   input logic [INSTR_W-1:0]     cmd_instr,
   input logic [BL_W-1:0]        cmd_bl,
   input byte_addr_t             cmd_byte_addr,
   input logic                   wr_en,
   input logic [PORT_MASK_W-1:0] wr_mask,
   input port_word_t             wr_data,
   input logic                   rd_en,
   input port_word_t             ddr_data,
   input logic                   word_drop,
   input logic                   wr_busy,
   input int                     phase,
   input logic                   tb_done,
   output int                    checks,
   output int                    errors,
   output int                    cycles,
   output logic                  report_done,
   output logic                  timed_out
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_CYCLES = 4000;

   port_word_t exp_words[$];
   port_word_t acc;
   int         n_bytes;
   byte_addr_t cur_addr;
   int         rd_cmds;
   int         rden_rises;
   int         rd_pulses;
   logic       drop_seen;
   logic       cmd_full_q;
   logic       wr_full_q;
   logic       drop_q;
   logic       set_q;
   logic       rden_q;
   logic       busy_q;
   logic       grp_now;                        // group of 16 bytes just completed
   logic       grp_q1;
   logic       grp_q2;
   logic       rden_rise;
   logic [2:0] rise_hist;                      // display strobe rises, last 3 cycles

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // first byte of a group lands in the top byte
   function automatic port_word_t pack_ref(input port_word_t prev, input logic [7:0] b);
      return {prev[PORT_DATA_W-9:0], b};
   endfunction

   // address of the next command, kind 0 write, 1 read
   function automatic byte_addr_t addr_ref(input byte_addr_t cur, input int kind);
      if (kind == 0) return cur + WORD_BYTES;
      return cur;
   endfunction

   function automatic port_word_t rd_word_ref(input int idx);
      return {96'd0, 32'hd000_0000 + idx};
   endfunction

   function automatic string test_name(input int p);
      case (p)
         1: return "write_sequence";
         3: return "read_commands";
         4: return "read_before_load";
         5: return "read_strobe";
         6: return "word_drop";
         default: return "reset";
      endcase
   endfunction

   task automatic check_value(input string what, input logic [127:0] exp_v,
                              input logic [127:0] act_v);
      checks++;
      if (exp_v !== act_v) begin
         errors++;
         $display("[FAIL] %s %s expected %0h actual %0h", test_name(phase), what, exp_v, act_v);
      end
   endtask

   task automatic report(input string msg);
      errors++;
      $display("error in %s: %s", test_name(phase), msg);
   endtask

   //////////////////////////////////////////////////////////////////////
   // comparing process
   //////////////////////////////////////////////////////////////////////

   initial begin
      checks      = 0;
      errors      = 0;
      cycles      = 0;
      report_done = 1'b0;
      timed_out   = 1'b0;
   end

   always @(posedge c3_clk0) begin
      cycles++;
      grp_now   = 1'b0;
      rden_rise = disp_rden && !rden_q;
      if (rst || !calib_done) begin
         exp_words.delete();
         acc        = '0;
         n_bytes    = 0;
         cur_addr   = '0;
         rd_cmds    = 0;
         rden_rises = 0;
         rd_pulses  = 0;
         drop_seen  = 1'b0;
         grp_q1     = 1'b0;
         grp_q2     = 1'b0;
         rise_hist  = '0;
      end else begin
         if (sd_byte_valid) begin
            acc = pack_ref(acc, sd_byte);
            n_bytes++;
            if (n_bytes == WORD_BYTES) begin
               exp_words.push_back(acc);
               n_bytes = 0;
               grp_now = 1'b1;
            end
         end
         if (word_drop && !drop_q) begin
            drop_seen = 1'b1;
            if (exp_words.size() < 2) begin
               report("word_drop rose with no second word waiting");
            end else begin
               void'(exp_words.pop_back());    // newest word never reaches DDR
            end
         end
         // slot fills two cycles after a group completes
         if (wr_busy && !busy_q && !grp_q2) begin
            report("wr_busy rose without a completed word");
         end
         if (!wr_busy && busy_q && !(cmd_en && cmd_instr == CMD_WRITE)) begin
            report("wr_busy fell without a write command");
         end
         if (wr_en) begin
            if (wr_full_q) report("write strobe issued while the write FIFO was full");
            if (!wr_busy) report("write strobe while no word was pending");
            if (exp_words.size() == 0) begin
               report("write strobe with no completed word");
            end else begin
               check_value("wr_data", exp_words.pop_front(), wr_data);
            end
            check_value("wr_mask", '0, wr_mask);
         end
         if (cmd_en) begin
            if (cmd_full_q) report("command issued while the command FIFO was full");
            if (cmd_instr == CMD_WRITE) begin
               cur_addr = addr_ref(cur_addr, 0);
               check_value("write cmd_bl", '0, cmd_bl);
               check_value("write cmd_byte_addr", cur_addr, cmd_byte_addr);
            end else if (cmd_instr == CMD_READ) begin
               rd_cmds++;
               if (!pic_read_done) report("read command before the picture was loaded");
               check_value("read cmd_bl", READ_BURST_LEN - 1, cmd_bl);
               check_value("read cmd_byte_addr", addr_ref(cur_addr, 1), cmd_byte_addr);
               cur_addr = cur_addr + READ_BURST_LEN * WORD_BYTES;
            end else begin
               report("command with an unknown instruction code");
            end
         end
         if (disp_addr_set && !set_q && pic_read_done) cur_addr = FRAME_BASE_ADDR;
         if (rden_rise) rden_rises++;
         if (rd_en) begin
            if (!rise_hist[2]) report("read strobe not three cycles after the display strobe rose");
            check_value("ddr_data", rd_word_ref(rd_pulses), ddr_data);
            rd_pulses++;
         end
      end
      cmd_full_q = cmd_full;
      wr_full_q  = wr_full;
      drop_q     = word_drop;
      set_q      = disp_addr_set;
      rden_q     = disp_rden;
      busy_q     = wr_busy;
      grp_q2     = grp_q1;
      grp_q1     = grp_now;
      rise_hist  = {rise_hist[1:0], rden_rise};

      if (tb_done && !report_done) begin
         if (rd_cmds != 2) report("wrong number of read commands");
         if (rd_pulses != rden_rises) report("read strobes do not match display strobe rises");
         if (!drop_seen) report("word_drop never rose");
         if (exp_words.size() != 0) report("completed words were never written");
         report_done = 1'b1;
      end else if (cycles >= MAX_CYCLES && !timed_out) begin
         $display("timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
         errors++;
         timed_out = 1'b1;
      end
   end

endmodule

/* tb_ddr_pic.sv */
module tb_ddr_pic import ddr_pic_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int READ_BURST_LEN = 64;

   logic             c3_clk0;
   logic             rst;
   logic             calib_done;
   logic [7:0]       sd_byte;
   logic             sd_byte_valid;
   logic             pic_read_done;
   logic             disp_addr_set;
   logic             disp_rd_cmd;
   logic             disp_rden;
   logic             cmd_full;
   logic             wr_full;
   port_word_t       rd_data;
   logic             cmd_en;
   logic [INSTR_W-1:0] cmd_instr;
   logic [BL_W-1:0]  cmd_bl;
   byte_addr_t       cmd_byte_addr;
   logic             wr_en;
   logic [PORT_MASK_W-1:0] wr_mask;
   port_word_t       wr_data;
   logic             rd_en;
   port_word_t       ddr_data;
   logic             wr_busy;
   logic             word_drop;

   int               phase;
   logic             tb_done;
   integer           seed;
   logic [31:0]      rd_idx;                   // controller read FIFO position
   int               checks;
   int               errors;
   int               cycles;
   logic             report_done;
   logic             timed_out;

   always #20 c3_clk0 = ~c3_clk0;

   //////////////////////////////////////////////////////////////////////
   // controller port model
   //////////////////////////////////////////////////////////////////////

   always @(posedge c3_clk0) begin
      if (rst) begin
         rd_idx <= '0;
      end else begin
         if (rd_en) rd_idx <= rd_idx + 1;      // next word of the read FIFO
      end
   end

   assign rd_data = {96'd0, 32'hd000_0000 + rd_idx};

   //////////////////////////////////////////////////////////////////////
   // stimulus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic send_word();
      for (int i = 0; i < 16; i++) begin
         @(negedge c3_clk0);
         sd_byte       = $random(seed);
         sd_byte_valid = 1'b1;
         if (($random(seed) & 3) == 0) begin
            @(negedge c3_clk0);
            sd_byte_valid = 1'b0;              // gap between bytes
         end
      end
      @(negedge c3_clk0);
      sd_byte_valid = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge c3_clk0);
   endtask

   // full flags may toggle while the word is on its way out
   task automatic wait_write_done(input bit rand_full);
      @(negedge c3_clk0);
      while (wr_busy) begin
         if (rand_full) begin
            wr_full  = (($random(seed) & 3) == 0);
            cmd_full = (($random(seed) & 3) == 0);
         end
         @(negedge c3_clk0);
      end
      if (rand_full) begin
         wr_full  = 1'b0;
         cmd_full = 1'b0;
      end
   endtask

   // sel 0 address reset, 1 read command, 2 read strobe
   task automatic raise_request(input int sel, input int hold);
      @(negedge c3_clk0);
      case (sel)
         0: disp_addr_set = 1'b1;
         1: disp_rd_cmd   = 1'b1;
         default: disp_rden = 1'b1;
      endcase
      idle_cycles(hold);
      disp_addr_set = 1'b0;
      disp_rd_cmd   = 1'b0;
      disp_rden     = 1'b0;
   endtask

   // command FIFO fills up now and then until the command goes out
   task automatic wait_cmd();
      @(negedge c3_clk0);
      while (!cmd_en) begin
         cmd_full = (($random(seed) & 1) == 1);
         @(negedge c3_clk0);
      end
      cmd_full = 1'b0;
   endtask

   initial begin
      seed          = 32'h60e9;
      c3_clk0       = 1'b0;
      rst           = 1'b1;
      calib_done    = 1'b0;
      sd_byte       = '0;
      sd_byte_valid = 1'b0;
      pic_read_done = 1'b0;
      disp_addr_set = 1'b0;
      disp_rd_cmd   = 1'b0;
      disp_rden     = 1'b0;
      cmd_full      = 1'b0;
      wr_full       = 1'b0;
      phase         = 0;
      tb_done       = 1'b0;
      repeat (5) @(negedge c3_clk0);
      rst        = 1'b0;
      calib_done = 1'b1;
      idle_cycles(3);

      phase = 1;                               // packing and write commands
      repeat (4) begin
         send_word();
         wait_write_done(1'b1);
      end

      phase = 4;                               // reads before the picture is loaded
      raise_request(1, 3);
      idle_cycles(4);
      raise_request(1, 6);
      idle_cycles(12);

      phase = 3;
      pic_read_done = 1'b1;
      raise_request(0, 2);
      idle_cycles(8);
      raise_request(1, 2);
      wait_cmd();
      idle_cycles(4);
      raise_request(1, 5);
      wait_cmd();
      idle_cycles(4);

      phase = 5;                               // read strobes of varying length
      for (int i = 1; i <= 5; i++) begin
         raise_request(2, i);
         idle_cycles(3 + i);
      end
      idle_cycles(6);

      phase = 6;                               // overflow of the pending slot
      @(negedge c3_clk0);
      wr_full = 1'b1;
      send_word();
      send_word();
      idle_cycles(10);
      wr_full = 1'b0;
      wait_write_done(1'b0);
      idle_cycles(10);
      tb_done = 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // end of run
   //////////////////////////////////////////////////////////////////////

   // after the final checks or on timeout
   initial begin
      wait (report_done || timed_out);
      $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   ddr_pic_top #(
      .READ_BURST_LEN (READ_BURST_LEN)
   ) ddr_pic_top_inst (
      .c3_clk0       (c3_clk0),
      .rst           (rst),
      .calib_done    (calib_done),
      .sd_byte       (sd_byte),
      .sd_byte_valid (sd_byte_valid),
      .pic_read_done (pic_read_done),
      .disp_addr_set (disp_addr_set),
      .disp_rd_cmd   (disp_rd_cmd),
      .disp_rden     (disp_rden),
      .cmd_full      (cmd_full),
      .wr_full       (wr_full),
      .rd_data       (rd_data),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_mask       (wr_mask),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .ddr_data      (ddr_data),
      .wr_busy       (wr_busy),
      .word_drop     (word_drop)
   );

   ddr_pic_checker #(
      .READ_BURST_LEN (READ_BURST_LEN)
   ) ddr_pic_checker_inst (
      .c3_clk0       (c3_clk0),
      .rst           (rst),
      .calib_done    (calib_done),
      .sd_byte       (sd_byte),
      .sd_byte_valid (sd_byte_valid),
      .pic_read_done (pic_read_done),
      .disp_addr_set (disp_addr_set),
      .disp_rden     (disp_rden),
      .cmd_full      (cmd_full),
      .wr_full       (wr_full),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_mask       (wr_mask),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .ddr_data      (ddr_data),
      .word_drop     (word_drop),
      .wr_busy       (wr_busy),
      .phase         (phase),
      .tb_done       (tb_done),
      .checks        (checks),
      .errors        (errors),
      .cycles        (cycles),
      .report_done   (report_done),
      .timed_out     (timed_out)
   );

endmodule

/* ddr_pic.f */
ddr_pic_pkg.sv
sd_word_packer.sv
req_edge_sync.sv
port_sequencer.sv
ddr_pic_top.sv
ddr_pic_checker.sv
tb_ddr_pic.sv

/* Bender.yml */
package:
  name: ddr_pic

sources:
  - ddr_pic_pkg.sv
  - sd_word_packer.sv
  - req_edge_sync.sv
  - port_sequencer.sv
  - ddr_pic_top.sv
  - target: simulation
    files:
      - ddr_pic_checker.sv
      - tb_ddr_pic.sv
